//--- list.f
source/csi2_data_types_pkg.sv
source/axi4_stream_if.sv
source/csi2_word_assembler.sv
source/csi2_pkt_handler.sv
source/csi2_frame_tracker.sv
source/csi2_rx_top.sv
testbench/csi2_rx_properties.sv
testbench/csi2_rx_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the CSI-2 receive testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/10ps --top-module csi2_rx_tb \
  -f list.f -o csi2_rx_sim

sim_out=$(./obj_dir/csi2_rx_sim || true)
echo "$sim_out"

if echo "$sim_out" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1

//--- source/axi4_stream_if.sv
`timescale 1ns/10ps

interface axi4_stream_if;
import csi2_data_types_pkg::*;

logic [TDATA_WIDTH - 1 : 0]     tdata;
logic                           tvalid;
logic                           tready;
logic [TDATA_WIDTH / 8 - 1 : 0] tstrb;
logic [TDATA_WIDTH / 8 - 1 : 0] tkeep;
logic                           tlast;
logic                           tid;
logic                           tdest;
logic                           tuser;

modport master
(
  output tdata, tvalid, tstrb, tkeep, tlast, tid, tdest, tuser,
  input  tready
);

modport slave
(
  input  tdata, tvalid, tstrb, tkeep, tlast, tid, tdest, tuser,
  output tready
);

endinterface

//--- source/csi2_data_types_pkg.sv
package csi2_data_types_pkg;

// Short packet data types
localparam logic [5 : 0] FRAME_START     = 6'h00;
localparam logic [5 : 0] FRAME_END       = 6'h01;

// First data type of the long packet range
localparam logic [5 : 0] LONG_PKT_MIN_DT = 6'h10;

localparam int BYTES_PER_WORD = 4;
localparam int TDATA_WIDTH    = 32;

// First word of every packet, as it sits on the 32-bit stream
typedef struct packed {
  logic [7 : 0]  ecc;
  logic [15 : 0] word_count;
  logic [1 : 0]  vc;
  logic [5 : 0]  dt;
} csi2_header_t;

endpackage

//--- source/csi2_frame_tracker.sv
`timescale 1ns/10ps

module csi2_frame_tracker
(
  input                 clk_i,
  input                 rst_i,
  input                 frame_start_i,
  input                 frame_end_i,
  axi4_stream_if        lines_i,
  output logic          frame_active_o,
  output logic [15 : 0] lines_per_frame_o,
  output logic [15 : 0] frame_count_o
);

logic [15 : 0] line_cnt;
logic          line_done;

// One line per long packet, marked by its last beat
assign line_done = lines_i.tvalid && lines_i.tready && lines_i.tlast;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    frame_active_o <= 1'b0;
  else
    if( frame_start_i )
      frame_active_o <= 1'b1;
    else
      if( frame_end_i )
        frame_active_o <= 1'b0;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    line_cnt <= '0;
  else
    if( frame_start_i )
      line_cnt <= '0;
    else
      if( frame_active_o && line_done )
        line_cnt <= line_cnt + 16'd1;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      lines_per_frame_o <= '0;
      frame_count_o     <= '0;
    end
  else
    if( frame_end_i )
      begin
        lines_per_frame_o <= line_cnt;
        frame_count_o     <= frame_count_o + 16'd1;
      end

endmodule

//--- source/csi2_pkt_handler.sv
`timescale 1ns/10ps

module csi2_pkt_handler
(
  input                 clk_i,
  input                 rst_i,
  axi4_stream_if.slave  pkt_i,
  output logic          frame_start_o,
  output logic          frame_end_o,
  axi4_stream_if.master pkt_o
);
import csi2_data_types_pkg::*;

enum logic [1 : 0] { IDLE_S,
                     RUN_S,
                     SKIP_CRC_S } state, next_state;

csi2_header_t                  header;
logic                          accept;
logic                          long_hdr;
logic                          last_word;
logic                          crc_word;
logic [15 : 0]                 byte_cnt;
logic [15 : 0]                 byte_cnt_next;
logic [15 : 0]                 pkt_size;
logic [BYTES_PER_WORD - 1 : 0] last_strb;

// No buffering here, ready goes straight upstream
assign pkt_i.tready = pkt_o.tready;

assign accept   = pkt_i.tvalid && pkt_i.tready;
assign header   = csi2_header_t'( pkt_i.tdata );
assign long_hdr = header.dt >= LONG_PKT_MIN_DT;

assign byte_cnt_next = byte_cnt + 16'( BYTES_PER_WORD );
assign last_word     = byte_cnt_next >= pkt_size;

// Second CRC byte spills into one more word
assign crc_word = pkt_size[1 : 0] == 2'd0 || pkt_size[1 : 0] == 2'd3;

always_comb
  for( int i = 0; i < BYTES_PER_WORD; i++ )
    last_strb[i] = pkt_size[1 : 0] == 2'd0 || i < int'( pkt_size[1 : 0] );

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    state <= IDLE_S;
  else
    state <= next_state;

always_comb
  begin
    next_state = state;
    case( state )
      IDLE_S:
        begin
          // Empty long packet carries only its CRC word
          if( accept && long_hdr )
            next_state = header.word_count == 16'd0 ? SKIP_CRC_S : RUN_S;
        end
      RUN_S:
        begin
          if( accept && last_word )
            next_state = crc_word ? SKIP_CRC_S : IDLE_S;
        end
      SKIP_CRC_S:
        begin
          if( accept )
            next_state = IDLE_S;
        end
      default:
        next_state = IDLE_S;
    endcase
  end

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    pkt_size <= '0;
  else
    if( state == IDLE_S && accept && long_hdr )
      pkt_size <= header.word_count;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    byte_cnt <= '0;
  else
    if( state != RUN_S )
      byte_cnt <= '0;
    else
      if( accept )
        byte_cnt <= byte_cnt_next;

// Short packet pulses, one cycle each
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      frame_start_o <= 1'b0;
      frame_end_o   <= 1'b0;
    end
  else
    begin
      frame_start_o <= accept && state == IDLE_S && header.dt == FRAME_START;
      frame_end_o   <= accept && state == IDLE_S && header.dt == FRAME_END;
    end

always_ff @( posedge clk_i )
  if( accept && state == RUN_S )
    pkt_o.tdata <= pkt_i.tdata;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      pkt_o.tvalid <= 1'b0;
      pkt_o.tlast  <= 1'b0;
      pkt_o.tstrb  <= '0;
    end
  else
    if( accept && state == RUN_S )
      begin
        pkt_o.tvalid <= 1'b1;
        pkt_o.tlast  <= last_word;
        pkt_o.tstrb  <= last_word ? last_strb : '1;
      end
    else
      if( pkt_o.tready )
        begin
          pkt_o.tvalid <= 1'b0;
          pkt_o.tlast  <= 1'b0;
        end

assign pkt_o.tkeep = pkt_o.tstrb;
assign pkt_o.tid   = 1'b0;
assign pkt_o.tdest = 1'b0;
assign pkt_o.tuser = 1'b0;

endmodule

//--- source/csi2_rx_top.sv
`timescale 1ns/10ps

module csi2_rx_top
(
  input                                                clk_i,
  input                                                rst_i,
  input        [7 : 0]                                 byte_i,
  input                                                byte_valid_i,
  input                                                sot_i,
  input                                                eot_i,
  input                                                tready_i,
  output logic [csi2_data_types_pkg::TDATA_WIDTH - 1 : 0]     tdata_o,
  output logic                                         tvalid_o,
  output logic [csi2_data_types_pkg::TDATA_WIDTH / 8 - 1 : 0] tstrb_o,
  output logic                                         tlast_o,
  output logic                                         frame_start_o,
  output logic                                         frame_end_o,
  output logic                                         frame_active_o,
  output logic [15 : 0]                                lines_per_frame_o,
  output logic [15 : 0]                                frame_count_o,
  output logic                                         overflow_o
);

axi4_stream_if raw_words();
axi4_stream_if payload();

csi2_word_assembler i_word_assembler
(
  .clk_i        ( clk_i        ),
  .rst_i        ( rst_i        ),
  .byte_i       ( byte_i       ),
  .byte_valid_i ( byte_valid_i ),
  .sot_i        ( sot_i        ),
  .eot_i        ( eot_i        ),
  .words_o      ( raw_words    ),
  .overflow_o   ( overflow_o   )
);

csi2_pkt_handler i_pkt_handler
(
  .clk_i         ( clk_i         ),
  .rst_i         ( rst_i         ),
  .pkt_i         ( raw_words     ),
  .frame_start_o ( frame_start_o ),
  .frame_end_o   ( frame_end_o   ),
  .pkt_o         ( payload       )
);

csi2_frame_tracker i_frame_tracker
(
  .clk_i             ( clk_i             ),
  .rst_i             ( rst_i             ),
  .frame_start_i     ( frame_start_o     ),
  .frame_end_i       ( frame_end_o       ),
  .lines_i           ( payload           ),
  .frame_active_o    ( frame_active_o    ),
  .lines_per_frame_o ( lines_per_frame_o ),
  .frame_count_o     ( frame_count_o     )
);

assign payload.tready = tready_i;

assign tdata_o  = payload.tdata;
assign tvalid_o = payload.tvalid;
assign tstrb_o  = payload.tstrb;
assign tlast_o  = payload.tlast;

endmodule

//--- source/csi2_word_assembler.sv
`timescale 1ns/10ps

module csi2_word_assembler
(
  input                 clk_i,
  input                 rst_i,
  input        [7 : 0]  byte_i,
  input                 byte_valid_i,
  input                 sot_i,
  input                 eot_i,
  axi4_stream_if.master words_o,
  output logic          overflow_o
);
import csi2_data_types_pkg::*;

logic [1 : 0]                      lane_cnt;
logic [1 : 0]                      lane_base;
logic [1 : 0]                      lane_next;
logic [BYTES_PER_WORD * 8 - 1 : 0] shift_q;
logic [BYTES_PER_WORD * 8 - 1 : 0] shift_next;
logic                              word_done;
logic                              flush;

// Byte phase restarts at start of transmission
assign lane_base  = sot_i ? 2'd0 : lane_cnt;
assign lane_next  = lane_base + 2'( byte_valid_i );
assign shift_next = byte_valid_i ? { byte_i, shift_q[BYTES_PER_WORD * 8 - 1 : 8] } : shift_q;

assign word_done = byte_valid_i && lane_base == 2'( BYTES_PER_WORD - 1 );
assign flush     = eot_i && !word_done && lane_next != 2'd0;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    lane_cnt <= '0;
  else
    if( eot_i )
      lane_cnt <= '0;
    else
      lane_cnt <= lane_next;

// Newest byte enters at the top lane
always_ff @( posedge clk_i )
  shift_q <= shift_next;

// Partial words slide down to the low lanes, zero-padded on top
always_ff @( posedge clk_i )
  if( word_done )
    words_o.tdata <= shift_next;
  else
    if( flush )
      words_o.tdata <= shift_next >> ( 8 * ( BYTES_PER_WORD - int'( lane_next ) ) );

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      words_o.tvalid <= 1'b0;
      words_o.tlast  <= 1'b0;
    end
  else
    if( word_done || flush )
      begin
        words_o.tvalid <= 1'b1;
        words_o.tlast  <= flush || eot_i;
      end
    else
      if( words_o.tready )
        begin
          words_o.tvalid <= 1'b0;
          words_o.tlast  <= 1'b0;
        end

// PHY cannot stall, a pending word gets overwritten
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    overflow_o <= 1'b0;
  else
    if( ( word_done || flush ) && words_o.tvalid && !words_o.tready )
      overflow_o <= 1'b1;

assign words_o.tstrb = '1;
assign words_o.tkeep = '1;
assign words_o.tid   = 1'b0;
assign words_o.tdest = 1'b0;
assign words_o.tuser = 1'b0;

endmodule

//--- testbench/csi2_rx_properties.sv
`timescale 1ns/10ps

module csi2_rx_properties
(
  input                                            clk_i,
  input                                            rst_i,
  input [csi2_data_types_pkg::TDATA_WIDTH - 1 : 0] tdata_i,
  input                                            tvalid_i,
  input                                            tready_i,
  input                                            tlast_i,
  input                                            frame_start_i,
  input                                            frame_end_i
);

// Stalled beat keeps its data
stall_hold_a : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  tvalid_i && !tready_i |=> $stable( tdata_i ) )
  else $error( "tdata_o changed while the payload stream was stalled" );

pulse_excl_a : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  !( frame_start_i && frame_end_i ) )
  else $error( "frame_start_o and frame_end_o high in the same cycle" );

last_valid_a : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  tlast_i |-> tvalid_i )
  else $error( "tlast_o high without tvalid_o" );

endmodule

//--- testbench/csi2_rx_tb.sv
`timescale 1ns/10ps

module csi2_rx_tb;
import csi2_data_types_pkg::*;

localparam int NUM_TESTS     = 12;
localparam int STALL_WC      = 16;
// Cycles per packet beyond its bytes for sot, eot, drain and settle
localparam int PKT_OVERHEAD  = 4;
// Header accepted, pulse registered, tracker updated
localparam int SETTLE_CYCLES = 4;

logic                           clk_i = 1'b0;
logic                           rst_i;
logic [7 : 0]                   byte_i;
logic                           byte_valid_i;
logic                           sot_i;
logic                           eot_i;
logic                           tready_i;
logic [TDATA_WIDTH - 1 : 0]     tdata_o;
logic                           tvalid_o;
logic [TDATA_WIDTH / 8 - 1 : 0] tstrb_o;
logic                           tlast_o;
logic                           frame_start_o;
logic                           frame_end_o;
logic                           frame_active_o;
logic [15 : 0]                  lines_per_frame_o;
logic [15 : 0]                  frame_count_o;
logic                           overflow_o;

// Stimulus and expected tracker state after each packet
string         test_name [NUM_TESTS];
logic [5 : 0]  test_dt [NUM_TESTS];
logic [15 : 0] test_wc [NUM_TESTS];
logic          exp_active [NUM_TESTS];
logic [15 : 0] exp_lines [NUM_TESTS];
logic [15 : 0] exp_frames [NUM_TESTS];
int            loaded = 0;

logic [TDATA_WIDTH - 1 : 0]     exp_data_q [$];
logic [TDATA_WIDTH / 8 - 1 : 0] exp_strb_q [$];
logic                           exp_last_q [$];

string         cur_test = "reset";
logic          ignore_output = 1'b0;
logic [15 : 0] exp_starts = '0;
logic [15 : 0] exp_ends = '0;
logic [15 : 0] seen_starts = '0;
logic [15 : 0] seen_ends = '0;
int            seed = 31;
int            value_errors = 0;
int            other_errors = 0;
int            cycle_cnt = 0;
int            cycle_limit = 0;

csi2_rx_top i_csi2_rx_top ( .* );

bind csi2_rx_top csi2_rx_properties i_csi2_rx_properties
(
  .clk_i         ( clk_i         ),
  .rst_i         ( rst_i         ),
  .tdata_i       ( tdata_o       ),
  .tvalid_i      ( tvalid_o      ),
  .tready_i      ( tready_i      ),
  .tlast_i       ( tlast_o       ),
  .frame_start_i ( frame_start_o ),
  .frame_end_i   ( frame_end_o   )
);

always #5 clk_i = ~clk_i;

always @( posedge clk_i )
  begin
    cycle_cnt <= cycle_cnt + 1;
    if( cycle_cnt >= cycle_limit )
      begin
        $display( "Run stopped at the cycle limit of %0d in test %s", cycle_limit, cur_test );
        $display( "Checks failed" );
        $finish;
      end
  end

task automatic check_word
(
  input string                          name,
  input logic [TDATA_WIDTH - 1 : 0]     exp_data,
  input logic [TDATA_WIDTH / 8 - 1 : 0] exp_strb,
  input logic                           exp_last,
  input logic [TDATA_WIDTH - 1 : 0]     act_data,
  input logic [TDATA_WIDTH / 8 - 1 : 0] act_strb,
  input logic                           act_last
);
  logic [TDATA_WIDTH - 1 : 0] mask;
  for( int i = 0; i < TDATA_WIDTH / 8; i++ )
    mask[8 * i +: 8] = {8{exp_strb[i]}};
  // Lanes without strobe hold CRC or padding
  if( ( act_data & mask ) !== exp_data || act_strb !== exp_strb || act_last !== exp_last )
    begin
      $display( "FAIL %s: expected data %h strb %b last %b, actual data %h strb %b last %b",
                name, exp_data, exp_strb, exp_last, act_data & mask, act_strb, act_last );
      value_errors++;
    end
endtask

task automatic check_count( input string name, input logic [15 : 0] exp, input logic [15 : 0] act );
  if( act !== exp )
    begin
      $display( "FAIL %s: expected %0d, actual %0d", name, exp, act );
      value_errors++;
    end
endtask

task automatic check_flag( input string name, input logic exp, input logic act );
  if( act !== exp )
    begin
      $display( "FAIL %s: expected %b, actual %b", name, exp, act );
      value_errors++;
    end
endtask

task automatic take_output();
  logic [TDATA_WIDTH - 1 : 0]     data;
  logic [TDATA_WIDTH / 8 - 1 : 0] strb;
  logic                           last;
  if( exp_data_q.size() == 0 )
    begin
      $display( "%s: output word with no packet expected", cur_test );
      other_errors++;
    end
  else
    begin
      data = exp_data_q.pop_front();
      strb = exp_strb_q.pop_front();
      last = exp_last_q.pop_front();
      check_word( cur_test, data, strb, last, tdata_o, tstrb_o, tlast_o );
    end
endtask

// Transfers and pulses are counted between edges
always @( negedge clk_i )
  if( !rst_i && !ignore_output )
    begin
      if( frame_start_o )
        seen_starts++;
      if( frame_end_o )
        seen_ends++;
      if( tvalid_o && tready_i )
        take_output();
    end

task automatic add_test
(
  input string         name,
  input logic [5 : 0]  dt,
  input logic [15 : 0] wc,
  input logic          active,
  input logic [15 : 0] lines,
  input logic [15 : 0] frames
);
  test_name[loaded]  = name;
  test_dt[loaded]    = dt;
  test_wc[loaded]    = wc;
  exp_active[loaded] = active;
  exp_lines[loaded]  = lines;
  exp_frames[loaded] = frames;
  loaded++;
endtask

function automatic int packet_bytes( input logic [5 : 0] dt, input logic [15 : 0] wc );
  if( dt >= LONG_PKT_MIN_DT )
    return BYTES_PER_WORD + int'( wc ) + 2;
  return BYTES_PER_WORD;
endfunction

task automatic next_cycle();
  @( posedge clk_i );
  #1;
endtask

task automatic send_byte( input logic [7 : 0] value );
  byte_i       = value;
  byte_valid_i = 1'b1;
  next_cycle();
  byte_valid_i = 1'b0;
endtask

task automatic send_packet( input logic [5 : 0] dt, input logic [15 : 0] wc );
  csi2_header_t                   hdr;
  logic [TDATA_WIDTH - 1 : 0]     word;
  logic [TDATA_WIDTH - 1 : 0]     acc;
  logic [TDATA_WIDTH / 8 - 1 : 0] strb;
  logic [7 : 0]                   value;
  int                             lane;
  hdr.ecc        = 8'h00;
  hdr.word_count = wc;
  hdr.vc         = 2'd0;
  hdr.dt         = dt;
  word           = hdr;
  acc            = '0;
  lane           = 0;
  if( dt == FRAME_START )
    exp_starts++;
  if( dt == FRAME_END )
    exp_ends++;
  sot_i = 1'b1;
  next_cycle();
  sot_i = 1'b0;
  for( int i = 0; i < BYTES_PER_WORD; i++ )
    send_byte( word[8 * i +: 8] );
  if( dt >= LONG_PKT_MIN_DT )
    begin
      for( int i = 0; i < int'( wc ); i++ )
        begin
          value              = 8'( $random( seed ) );
          acc[8 * lane +: 8] = value;
          lane++;
          if( lane == BYTES_PER_WORD || i == int'( wc ) - 1 )
            begin
              for( int k = 0; k < BYTES_PER_WORD; k++ )
                strb[k] = k < lane;
              exp_data_q.push_back( acc );
              exp_strb_q.push_back( strb );
              exp_last_q.push_back( i == int'( wc ) - 1 );
              acc  = '0;
              lane = 0;
            end
          send_byte( value );
        end
      // Two CRC bytes that the DUT never checks
      send_byte( 8'( $random( seed ) ) );
      send_byte( 8'( $random( seed ) ) );
    end
  eot_i = 1'b1;
  next_cycle();
  eot_i = 1'b0;
endtask

task automatic check_state( input int idx );
  while( exp_data_q.size() != 0 )
    @( negedge clk_i );
  repeat( SETTLE_CYCLES )
    @( negedge clk_i );
  check_count( { test_name[idx], " frame starts" }, exp_starts, seen_starts );
  check_count( { test_name[idx], " frame ends" }, exp_ends, seen_ends );
  check_flag( { test_name[idx], " frame active" }, exp_active[idx], frame_active_o );
  check_count( { test_name[idx], " lines per frame" }, exp_lines[idx], lines_per_frame_o );
  check_count( { test_name[idx], " frame count" }, exp_frames[idx], frame_count_o );
  check_flag( { test_name[idx], " overflow" }, 1'b0, overflow_o );
  next_cycle();
endtask

// Stream stalls once the first payload word is out, so later words overwrite pending ones
task automatic stall_test();
  cur_test      = "stall_overflow";
  ignore_output = 1'b1;
  fork
    send_packet( 6'h2A, 16'( STALL_WC ) );
    begin
      wait( tvalid_o );
      #1;
      tready_i = 1'b0;
    end
  join
  @( negedge clk_i );
  check_flag( "stall_overflow set", 1'b1, overflow_o );
  next_cycle();
  tready_i = 1'b1;
  repeat( SETTLE_CYCLES )
    @( negedge clk_i );
  check_flag( "stall_overflow held", 1'b1, overflow_o );
endtask

task automatic load_table();
  add_test( "frame1_start", FRAME_START, 16'd0, 1'b1, 16'd0, 16'd0 );
  add_test( "long_wc8", 6'h2A, 16'd8, 1'b1, 16'd0, 16'd0 );
  add_test( "long_wc9", 6'h2A, 16'd9, 1'b1, 16'd0, 16'd0 );
  add_test( "long_wc10", 6'h2A, 16'd10, 1'b1, 16'd0, 16'd0 );
  add_test( "frame1_end", FRAME_END, 16'd0, 1'b0, 16'd3, 16'd1 );
  add_test( "short_dt02", 6'h02, 16'd0, 1'b0, 16'd3, 16'd1 );
  add_test( "frame2_start", FRAME_START, 16'd1, 1'b1, 16'd3, 16'd1 );
  add_test( "long_wc11", 6'h2B, 16'd11, 1'b1, 16'd3, 16'd1 );
  add_test( "long_wc4", 6'h2B, 16'd4, 1'b1, 16'd3, 16'd1 );
  add_test( "long_wc16", 6'h2B, 16'd16, 1'b1, 16'd3, 16'd1 );
  add_test( "frame2_end", FRAME_END, 16'd1, 1'b0, 16'd3, 16'd2 );
  add_test( "long_wc7_no_frame", 6'h2A, 16'd7, 1'b0, 16'd3, 16'd2 );
endtask

initial
  begin
    rst_i        = 1'b1;
    byte_i       = '0;
    byte_valid_i = 1'b0;
    sot_i        = 1'b0;
    eot_i        = 1'b0;
    tready_i     = 1'b1;
    load_table();
    cycle_limit = 200 + packet_bytes( 6'h2A, 16'( STALL_WC ) ) + PKT_OVERHEAD;
    for( int i = 0; i < NUM_TESTS; i++ )
      cycle_limit += packet_bytes( test_dt[i], test_wc[i] ) + PKT_OVERHEAD;
    repeat( 4 )
      @( posedge clk_i );
    #1;
    rst_i = 1'b0;
    next_cycle();
    for( int i = 0; i < NUM_TESTS; i++ )
      begin
        cur_test = test_name[i];
        send_packet( test_dt[i], test_wc[i] );
        check_state( i );
      end
    stall_test();
    $display( "Errors: %0d value mismatches, %0d other failures", value_errors, other_errors );
    if( value_errors == 0 && other_errors == 0 )
      $display( "All checks passed" );
    else
      $display( "Checks failed" );
    $finish;
  end

endmodule
